// ==== verilog/memPkg.sv ====
package memPkg;

    // kind of transfer launched by the arbiter
    typedef enum logic [1:0] {
        opFetch = 2'd0,
        opLoad  = 2'd1,
        opStore = 2'd2
    } memOp;

    // byte-serial sequencer states
    typedef enum logic [1:0] {
        stIdle  = 2'd0,
        stIssue = 2'd1,
        stDrain = 2'd2
    } seqState;

    // RAM direction
    localparam logic ramRead  = 1'b0;
    localparam logic ramWrite = 1'b1;

    // addr[17:16] equal to this selects the I/O region
    localparam logic [1:0] IoRegionTop = 2'd3;

endpackage

// ==== verilog/memReqIf.sv ====
`timescale 1ns/1ps

interface memReqIf #(
    parameter int AddrWidth = 17
);
    import memPkg::*;

    // one-cycle launch strobe, only while busy is low
    logic                 start;
    memOp                 op;
    logic [AddrWidth-1:0] addr;
    logic [2:0]           len;
    logic [31:0]          wdata;
    // high from the cycle after start up to the done cycle
    logic                 busy;

    modport source (
        output start, op, addr, len, wdata,
        input  busy
    );

    modport sink (
        input  start, op, addr, len, wdata,
        output busy
    );

endinterface

// ==== verilog/memArbiter.sv ====
`timescale 1ns/1ps

module memArbiter #(
    parameter int AddrWidth = 17
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        rdy,
    input  logic        ioBufferFull,

    input  logic        fetchEn,
    input  logic [31:0] fetchAddr,

    input  logic        dataEn,
    input  logic        dataStore,
    input  logic [2:0]  dataLen,
    input  logic [31:0] dataAddr,
    input  logic [31:0] dataWdata,

    input  logic        fetchDone,
    input  logic        dataDone,

    memReqIf.source     req
);
    import memPkg::*;

    logic ioStore;
    logic dataOk;
    logic fetchOk;
    logic fetchBlock;
    logic dataBlock;
    logic launch;

    assign ioStore = dataStore && (dataAddr[17:16] == IoRegionTop);

    // stores to the I/O region wait for room in the output buffer
    assign dataOk  = dataEn && !dataBlock && !(ioStore && ioBufferFull);
    assign fetchOk = fetchEn && !fetchBlock;

    // start is registered, so skip the cycle it is already high
    assign launch = !req.busy && !req.start && (dataOk || fetchOk);

    always_ff @(posedge clk) begin
        if (rst) begin
            req.start  <= 1'b0;
            fetchBlock <= 1'b0;
            dataBlock  <= 1'b0;
        end else if (rdy) begin
            req.start  <= launch;
            // a client's enable may still be up right after its done
            fetchBlock <= fetchDone;
            dataBlock  <= dataDone;
        end
    end

    // operands of the chosen client, data wins over fetch
    always_ff @(posedge clk) begin
        if (rdy && launch) begin
            if (dataOk) begin
                req.op    <= dataStore ? opStore : opLoad;
                req.addr  <= dataAddr[AddrWidth-1:0];
                req.len   <= dataLen;
                req.wdata <= dataWdata;
            end else begin
                req.op    <= opFetch;
                req.addr  <= fetchAddr[AddrWidth-1:0];
                req.len   <= 3'd4;
                req.wdata <= '0;
            end
        end
    end

    // the sequencer must have finished before a new launch
    startWhileIdle: assert property (
        @(posedge clk) disable iff (rst)
        req.start |-> !req.busy
    ) else $error("start pulsed while the sequencer was busy");

endmodule

// ==== verilog/memSequencer.sv ====
`timescale 1ns/1ps

module memSequencer #(
    parameter int AddrWidth = 17
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,

    memReqIf.sink                req,

    input  logic [7:0]           memRdata,
    output logic [AddrWidth-1:0] memAddr,
    output logic                 memRw,
    output logic [7:0]           memWdata,

    output logic                 fetchDone,
    output logic                 dataDone,
    output logic [31:0]          inst,
    output logic [31:0]          rdata
);
    import memPkg::*;

    seqState              state;
    seqState              stateNext;
    memOp                 opQ;
    logic [AddrWidth-1:0] baseQ;
    logic [2:0]           lenQ;
    logic [31:0]          wdataQ;
    logic [31:0]          word;

    logic [1:0]           issueIdx;
    logic [1:0]           issueNext;
    logic [1:0]           capIdx;
    logic [1:0]           capNext;
    logic                 rwNext;

    // address presented last cycle and its byte index
    logic                 flightValid;
    logic [1:0]           flightIdx;

    logic                 isStore;
    logic                 lastIssue;
    logic                 capture;
    logic                 readDone;
    logic                 storeDone;
    logic                 doneNow;
    logic [AddrWidth-1:0] addrBase;
    logic [31:0]          wdataSel;
    logic [31:0]          assembled;

    assign isStore   = (opQ == opStore);
    assign lastIssue = ({1'b0, issueIdx} == lenQ - 3'd1);

    // only take the byte if it is the next missing lane
    assign capture   = (state != stIdle) && !isStore && flightValid && (flightIdx == capIdx);
    assign readDone  = capture && ({1'b0, capIdx} == lenQ - 3'd1);
    assign storeDone = isStore && (state == stDrain);
    assign doneNow   = rdy && (readDone || storeDone);

    assign fetchDone = doneNow && (opQ == opFetch);
    assign dataDone  = doneNow && (opQ != opFetch);
    assign req.busy  = (state != stIdle);

    assign addrBase = (state == stIdle) ? req.addr : baseQ;
    assign wdataSel = (state == stIdle) ? req.wdata : wdataQ;

    always_comb begin
        stateNext = state;
        issueNext = issueIdx;
        capNext   = capIdx;
        rwNext    = memRw;
        if (!rdy) begin
            rwNext = ramRead;
            // rewind so the oldest missing byte is read again
            if (state != stIdle && !isStore) begin
                stateNext = stIssue;
                issueNext = capIdx;
            end
        end else begin
            if (capture) begin
                capNext = capIdx + 2'd1;
            end
            case (state)
                stIdle: begin
                    if (req.start) begin
                        stateNext = stIssue;
                        issueNext = '0;
                        capNext   = '0;
                        rwNext    = (req.op == opStore) ? ramWrite : ramRead;
                    end
                end
                stIssue: begin
                    if (readDone) begin
                        stateNext = stIdle;
                    end else if (isStore && memRw == ramRead) begin
                        // write again the byte cut off by a stall
                        rwNext = ramWrite;
                    end else if (lastIssue) begin
                        stateNext = stDrain;
                        rwNext    = ramRead;
                    end else begin
                        issueNext = issueIdx + 2'd1;
                    end
                end
                stDrain: begin
                    if (readDone || storeDone) begin
                        stateNext = stIdle;
                    end else if (!isStore) begin
                        stateNext = stIssue;
                        issueNext = capNext;
                    end
                end
                default: stateNext = stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= stIdle;
            issueIdx    <= '0;
            capIdx      <= '0;
            memRw       <= ramRead;
            flightValid <= 1'b0;
        end else begin
            state       <= stateNext;
            issueIdx    <= issueNext;
            capIdx      <= capNext;
            memRw       <= rwNext;
            // the RAM reads every cycle, stall or not
            flightValid <= (state == stIssue) && !isStore;
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && rdy && req.start) begin
            opQ    <= req.op;
            baseQ  <= req.addr;
            lenQ   <= req.len;
            wdataQ <= req.wdata;
        end
        if (rdy && capture) begin
            word[{capIdx, 3'b000} +: 8] <= memRdata;
        end
        flightIdx <= issueIdx;
        memAddr   <= addrBase + AddrWidth'(issueNext);
        memWdata  <= wdataSel[{issueNext, 3'b000} +: 8];
    end

    // little-endian, newest byte straight from the RAM
    always_comb begin
        assembled = word;
        assembled[{capIdx, 3'b000} +: 8] = memRdata;
    end

    always_comb begin
        case (lenQ)
            3'd1:    rdata = {24'd0, assembled[7:0]};
            3'd2:    rdata = {16'd0, assembled[15:0]};
            default: rdata = assembled;
        endcase
    end

    assign inst = assembled;

    lenLegal: assert property (
        @(posedge clk) disable iff (rst)
        (state != stIdle) |-> (lenQ inside {3'd1, 3'd2, 3'd4})
    ) else $error("illegal transfer length %0d", lenQ);

    // a done pulse lasts one cycle, so the other port cannot overlap it
    oneDone: assert property (
        @(posedge clk) disable iff (rst)
        (fetchDone || dataDone) |=> !(fetchDone || dataDone)
    ) else $error("done pulse longer than one cycle");

    // a fetch transfer never writes the RAM
    fetchNotStore: assert property (
        @(posedge clk) disable iff (rst)
        (state != stIdle && opQ == opFetch) |-> (memRw == ramRead)
    ) else $error("RAM write during a fetch transfer");

endmodule

// ==== verilog/memCtrl.sv ====
`timescale 1ns/1ps

module memCtrl #(
    parameter int AddrWidth = 17
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,

    // RAM side
    input  logic [7:0]           memRdata,
    output logic [AddrWidth-1:0] memAddr,
    output logic                 memRw,
    output logic [7:0]           memWdata,

    // instruction fetch
    input  logic                 fetchEn,
    input  logic [31:0]          fetchAddr,
    output logic                 fetchDone,
    output logic [31:0]          inst,

    // data port
    input  logic                 dataEn,
    input  logic                 dataStore,
    input  logic [2:0]           dataLen,
    input  logic [31:0]          dataAddr,
    input  logic [31:0]          dataWdata,
    output logic                 dataDone,
    output logic [31:0]          rdata
);

    memReqIf #(.AddrWidth(AddrWidth)) reqIf_i ();

    memArbiter #(.AddrWidth(AddrWidth)) arbiter_i (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .dataEn       (dataEn),
        .dataStore    (dataStore),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        // done pulses feed the per-client block
        .fetchDone    (fetchDone),
        .dataDone     (dataDone),
        .req          (reqIf_i.source)
    );

    memSequencer #(.AddrWidth(AddrWidth)) sequencer_i (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .req       (reqIf_i.sink),
        .memRdata  (memRdata),
        .memAddr   (memAddr),
        .memRw     (memRw),
        .memWdata  (memWdata),
        .fetchDone (fetchDone),
        .dataDone  (dataDone),
        .inst      (inst),
        .rdata     (rdata)
    );

endmodule

// ==== tb/ramModel.sv ====
`timescale 1ns/1ps

module ramModel #(
    parameter int AddrWidth = 17
) (
    input  logic                 clk,
    input  logic [AddrWidth-1:0] addr,
    input  logic                 rw,
    input  logic [7:0]           wdata,
    output logic [7:0]           rdata
);
    import memPkg::*;

    logic [7:0] mem [0:(1 << AddrWidth) - 1];

    // read data lags the address by one cycle, old byte on a write
    always @(posedge clk) begin
        rdata <= mem[addr];
        if (rw == ramWrite) begin
            mem[addr] = wdata;
        end
    end

    // backdoor access
    task automatic poke(
        input logic [AddrWidth-1:0] a,
        input logic [7:0]           d
    );
        mem[a] = d;
    endtask

    function automatic logic [7:0] peek(input logic [AddrWidth-1:0] a);
        return mem[a];
    endfunction

endmodule

// ==== tb/memCtrlTb.sv ====
`timescale 1ns/1ps

module memCtrlTb;
    import memPkg::*;

    localparam int AddrWidth = 17;
    localparam int MemSize   = 1 << AddrWidth;
    localparam int MaxWait   = 200;

    logic                 clk;
    logic                 rst;
    logic                 rdy;
    logic                 ioBufferFull;
    logic [7:0]           memRdata;
    logic [AddrWidth-1:0] memAddr;
    logic                 memRw;
    logic [7:0]           memWdata;
    logic                 fetchEn;
    logic [31:0]          fetchAddr;
    logic                 fetchDone;
    logic [31:0]          inst;
    logic                 dataEn;
    logic                 dataStore;
    logic [2:0]           dataLen;
    logic [31:0]          dataAddr;
    logic [31:0]          dataWdata;
    logic                 dataDone;
    logic [31:0]          rdata;

    // testbench copy of the RAM contents
    logic [7:0]  shadow [0:MemSize-1];
    string       curTest;
    logic [31:0] expInst;
    logic [31:0] expData;
    bit          checkData;
    bit          stallOn;
    bit          holdWatch;
    int          errors;
    int          errAtStart;
    int          passCount;
    int          failCount;
    int          seed;

    memCtrl #(.AddrWidth(AddrWidth)) dut_i (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .memRdata     (memRdata),
        .memAddr      (memAddr),
        .memRw        (memRw),
        .memWdata     (memWdata),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .inst         (inst),
        .dataEn       (dataEn),
        .dataStore    (dataStore),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .dataDone     (dataDone),
        .rdata        (rdata)
    );

    ramModel #(.AddrWidth(AddrWidth)) ram_i (
        .clk   (clk),
        .addr  (memAddr),
        .rw    (memRw),
        .wdata (memWdata),
        .rdata (memRdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // random stalls, one chance in four per cycle
    always @(posedge clk) begin
        rdy <= stallOn ? (($urandom % 4) != 0) : 1'b1;
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (fetchDone) begin
                assert (inst == expInst) else begin
                    $display("[ERROR] %s: inst expected %h, actual %h", curTest, expInst, inst);
                    errors++;
                end
            end
            if (dataDone && checkData) begin
                assert (rdata == expData) else begin
                    $display("[ERROR] %s: rdata expected %h, actual %h", curTest, expData, rdata);
                    errors++;
                end
            end
            if (holdWatch) begin
                assert (!dataDone && memRw == ramRead) else begin
                    $display("%s: the held I/O store reached the RAM", curTest);
                    errors++;
                end
            end
        end
    end

    // little-endian, zero-extended to len bytes
    function automatic logic [31:0] refAccess(input logic [31:0] addr, input logic [2:0] len);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < len; i++) begin
            value[8*i +: 8] = shadow[(addr + i) & (MemSize - 1)];
        end
        return value;
    endfunction

    function automatic logic [2:0] pickLen();
        case ($urandom % 3)
            0:       return 3'd1;
            1:       return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    task automatic applyStore(input logic [31:0] addr, input logic [2:0] len,
                              input logic [31:0] wdata);
        for (int i = 0; i < len; i++) begin
            shadow[(addr + i) & (MemSize - 1)] = wdata[8*i +: 8];
        end
    endtask

    task automatic preloadRam();
        logic [7:0] b;
        for (int a = 0; a < MemSize; a++) begin
            b = 8'($urandom);
            shadow[a] = b;
            ram_i.poke(AddrWidth'(a), b);
        end
    endtask

    // the stored bytes and their neighbours
    task automatic checkBytes(input logic [31:0] addr);
        logic [AddrWidth-1:0] a;
        logic [7:0]           got;
        for (int i = -1; i < 5; i++) begin
            a = AddrWidth'(addr + i);
            got = ram_i.peek(a);
            assert (got == shadow[a]) else begin
                $display("[ERROR] %s: byte %h expected %h, actual %h", curTest, a, shadow[a], got);
                errors++;
            end
        end
    endtask

    task automatic beginTest(input string name);
        curTest = name;
        errAtStart = errors;
    endtask

    task automatic endTest();
        if (errors == errAtStart) begin
            passCount++;
            $display("%s: pass", curTest);
        end else begin
            failCount++;
            $display("%s: fail, %0d errors", curTest, errors - errAtStart);
        end
    endtask

    task automatic finishRun();
        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0 && errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    task automatic waitDone(input bit wantData, output bit sawOther);
        int n;
        bit hit;
        n = 0;
        hit = 1'b0;
        sawOther = 1'b0;
        while (!hit && n < MaxWait) begin
            @(posedge clk);
            n++;
            hit = wantData ? dataDone : fetchDone;
            if (wantData ? fetchDone : dataDone) begin
                sawOther = 1'b1;
            end
        end
        if (!hit) begin
            $display("%s: no %s done within %0d cycles", curTest,
                     wantData ? "data" : "fetch", MaxWait);
            errors++;
            endTest();
            finishRun();
        end
    endtask

    task automatic fetchWord(input logic [31:0] addr);
        bit other;
        @(posedge clk);
        expInst = refAccess(addr, 3'd4);
        fetchEn <= 1'b1;
        fetchAddr <= addr;
        waitDone(1'b0, other);
        fetchEn <= 1'b0;
    endtask

    task automatic loadData(input logic [31:0] addr, input logic [2:0] len);
        bit other;
        @(posedge clk);
        expData = refAccess(addr, len);
        checkData = 1'b1;
        dataEn <= 1'b1;
        dataStore <= 1'b0;
        dataLen <= len;
        dataAddr <= addr;
        waitDone(1'b1, other);
        dataEn <= 1'b0;
    endtask

    task automatic storeData(input logic [31:0] addr, input logic [2:0] len,
                             input logic [31:0] wdata);
        bit other;
        @(posedge clk);
        checkData = 1'b0;
        dataEn <= 1'b1;
        dataStore <= 1'b1;
        dataLen <= len;
        dataAddr <= addr;
        dataWdata <= wdata;
        waitDone(1'b1, other);
        dataEn <= 1'b0;
        dataStore <= 1'b0;
        applyStore(addr, len, wdata);
        checkBytes(addr);
    endtask

    task automatic bothPorts(input logic [31:0] fa, input logic [31:0] da, input logic [2:0] len);
        bit other;
        @(posedge clk);
        expInst = refAccess(fa, 3'd4);
        expData = refAccess(da, len);
        checkData = 1'b1;
        fetchEn <= 1'b1;
        fetchAddr <= fa;
        dataEn <= 1'b1;
        dataStore <= 1'b0;
        dataLen <= len;
        dataAddr <= da;
        waitDone(1'b1, other);
        dataEn <= 1'b0;
        assert (!other) else begin
            $display("%s: fetch finished before the data access", curTest);
            errors++;
        end
        waitDone(1'b0, other);
        fetchEn <= 1'b0;
    endtask

    task automatic ioHold(input logic [31:0] ioAddr, input logic [31:0] wdata,
                          input logic [31:0] fa);
        bit other;
        @(posedge clk);
        checkData = 1'b0;
        expInst = refAccess(fa, 3'd4);
        holdWatch = 1'b1;
        ioBufferFull <= 1'b1;
        dataEn <= 1'b1;
        dataStore <= 1'b1;
        dataLen <= 3'd4;
        dataAddr <= ioAddr;
        dataWdata <= wdata;
        fetchEn <= 1'b1;
        fetchAddr <= fa;
        waitDone(1'b0, other);
        fetchEn <= 1'b0;
        repeat (20) @(posedge clk);
        holdWatch = 1'b0;
        ioBufferFull <= 1'b0;
        waitDone(1'b1, other);
        dataEn <= 1'b0;
        dataStore <= 1'b0;
        applyStore(ioAddr, 3'd4, wdata);
        checkBytes(ioAddr);
        loadData(ioAddr, 3'd4);
    endtask

    initial begin
        logic [31:0] a;
        logic [2:0]  len;
        seed = 67;
        void'($urandom(seed));
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataStore = 1'b0;
        dataLen = 3'd4;
        dataAddr = '0;
        dataWdata = '0;
        stallOn = 1'b0;
        holdWatch = 1'b0;
        checkData = 1'b0;
        errors = 0;
        passCount = 0;
        failCount = 0;
        preloadRam();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        beginTest("reset");
        assert (!fetchDone && !dataDone && memRw == ramRead) else begin
            $display("%s: outputs not idle after reset", curTest);
            errors++;
        end
        endTest();

        beginTest("fetch");
        repeat (8) fetchWord(($urandom % MemSize) & ~32'd3);
        endTest();

        beginTest("load");
        repeat (12) loadData($urandom % MemSize, pickLen());
        endTest();

        beginTest("store");
        repeat (12) begin
            a = $urandom % MemSize;
            len = pickLen();
            storeData(a, len, $urandom);
            loadData(a, len);
        end
        endTest();

        beginTest("both enables");
        repeat (4) bothPorts(($urandom % MemSize) & ~32'd3, $urandom % MemSize, pickLen());
        endTest();

        beginTest("stall");
        stallOn = 1'b1;
        repeat (16) begin
            a = $urandom % MemSize;
            case ($urandom % 3)
                0:       fetchWord(a & ~32'd3);
                1:       loadData(a, pickLen());
                default: storeData(a, pickLen(), $urandom);
            endcase
        end
        stallOn = 1'b0;
        repeat (2) @(posedge clk);
        endTest();

        beginTest("io hold");
        repeat (2) ioHold(32'h0003_0000 | ($urandom & 32'h0000_fffc), $urandom,
                          ($urandom % MemSize) & ~32'd3);
        endTest();

        finishRun();
    end

endmodule

// ==== build.f ====
verilog/memPkg.sv
verilog/memReqIf.sv
verilog/memArbiter.sv
verilog/memSequencer.sv
verilog/memCtrl.sv
tb/ramModel.sv
tb/memCtrlTb.sv

// ==== Bender.yml ====
package:
  name: memctrl

sources:
  # RTL in compile order
  - files:
      - verilog/memPkg.sv
      - verilog/memReqIf.sv
      - verilog/memArbiter.sv
      - verilog/memSequencer.sv
      - verilog/memCtrl.sv

  # testbench and RAM model
  - target: simulation
    files:
      - tb/ramModel.sv
      - tb/memCtrlTb.sv
